// File: common/isp_pkg.sv
package isp_pkg;

    // ====================
    // picture geometry
    // ====================
    localparam int IMG_DIM        = 8;
    localparam int CENTER_DIM     = 6;
    localparam int PIX_PER_BEAT   = 16;
    localparam int BEATS_PER_CHAN = 4;
    localparam int BEATS_PER_PIC  = 12;
    localparam int PIC_BYTES      = 192;

    // bus widths
    localparam int DATA_W = 128;
    localparam int ADDR_W = 32;

    typedef enum logic {
        MODE_FOCUS    = 1'b0,
        MODE_EXPOSURE = 1'b1
    } isp_mode_e;

    typedef enum logic [1:0] {
        RATIO_QUARTER = 2'd0,
        RATIO_HALF    = 2'd1,
        RATIO_ONE     = 2'd2,
        RATIO_DOUBLE  = 2'd3
    } ratio_e;

    // ====================
    // bundles
    // ====================
    typedef struct packed {
        logic [3:0] pic_no;
        isp_mode_e  mode;
        ratio_e     ratio;
    } isp_cmd_t;

    // one accepted read beat, two picture rows of one channel
    typedef struct packed {
        logic              valid;
        logic [1:0]        chan;
        logic [1:0]        row_pair;
        logic              last;
        logic [DATA_W-1:0] data;
    } pix_beat_t;

    typedef struct packed {
        logic       valid;
        logic [9:0] c2;
        logic [9:0] c4;
        logic [9:0] c6;
    } focus_res_t;

    typedef struct packed {
        logic        valid;
        logic [13:0] sum;
    } expo_res_t;

    typedef struct packed {
        logic [ADDR_W-1:0] araddr;
        logic [7:0]        arlen;
        logic              arvalid;
    } axi_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              rlast;
        logic              rvalid;
    } axi_r_t;

endpackage

// File: design/isp_cmd_decode.sv
`timescale 1ns/1ps

module isp_cmd_decode #(
    parameter logic [isp_pkg::ADDR_W-1:0] PIC_BASE = 32'h10000
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  isp_pkg::isp_cmd_t           in_cmd,
    input  logic                        out_valid,
    output isp_pkg::isp_cmd_t           cmd,
    output logic                        rd_start,
    output logic [isp_pkg::ADDR_W-1:0]  rd_addr
);

    typedef logic [isp_pkg::ADDR_W-1:0] addr_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_FETCH = 2'd1,
        ST_WAIT  = 2'd2
    } state_e;

    state_e state_q;
    state_e state_d;

    // ====================
    // sequencing FSM
    // ====================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (in_valid) state_d = ST_FETCH;
            ST_FETCH: state_d = ST_WAIT;
            ST_WAIT:  if (out_valid) state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // commands only land while idle, busy ones are dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd <= '0;
        end else if (state_q == ST_IDLE && in_valid) begin
            cmd <= in_cmd;
        end
    end

    // one-cycle kick for the reader
    assign rd_start = (state_q == ST_FETCH);

    assign rd_addr = PIC_BASE + addr_t'(cmd.pic_no) * addr_t'(isp_pkg::PIC_BYTES);

endmodule

// File: design/dram_reader.sv
`timescale 1ns/1ps

module dram_reader (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rd_start,
    input  logic [isp_pkg::ADDR_W-1:0]  rd_addr,
    input  logic                        axi_ar_ready,
    input  isp_pkg::axi_r_t             axi_r,
    output isp_pkg::axi_ar_t            axi_ar,
    output logic                        axi_r_ready,
    output isp_pkg::pix_beat_t          beat
);

    logic [isp_pkg::ADDR_W-1:0] araddr_q;
    logic                       arvalid_q;
    logic                       rready_q;
    logic [3:0]                 beat_cnt_q;
    logic                       ar_hs;
    logic                       r_hs;

    logic                       bvalid_q;
    logic [1:0]                 bchan_q;
    logic [1:0]                 brow_q;
    logic                       blast_q;
    logic [isp_pkg::DATA_W-1:0] bdata_q;

    assign ar_hs = arvalid_q & axi_ar_ready;
    assign r_hs  = axi_r.rvalid & rready_q;

    // ====================
    // read address / data handshakes
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid_q <= 1'b0;
            rready_q  <= 1'b0;
        end else begin
            if (rd_start) begin
                arvalid_q <= 1'b1;
            end else if (ar_hs) begin
                arvalid_q <= 1'b0;
            end
            if (ar_hs) begin
                rready_q <= 1'b1;
            end else if (r_hs && axi_r.rlast) begin
                rready_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start) begin
            araddr_q <= rd_addr;
        end
    end

    // accepted beat counter, R then G then B
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt_q <= '0;
            bvalid_q   <= 1'b0;
            bchan_q    <= '0;
            brow_q     <= '0;
            blast_q    <= 1'b0;
        end else begin
            if (rd_start) begin
                beat_cnt_q <= '0;
            end else if (r_hs) begin
                beat_cnt_q <= (beat_cnt_q == 4'(isp_pkg::BEATS_PER_PIC - 1)) ? '0
                                                                             : beat_cnt_q + 4'd1;
            end
            bvalid_q <= r_hs;
            bchan_q  <= 2'(beat_cnt_q / isp_pkg::BEATS_PER_CHAN);
            brow_q   <= 2'(beat_cnt_q % isp_pkg::BEATS_PER_CHAN);
            blast_q  <= r_hs && (beat_cnt_q == 4'(isp_pkg::BEATS_PER_PIC - 1));
        end
    end

    always_ff @(posedge clk) begin
        bdata_q <= axi_r.rdata;
    end

    assign axi_ar = '{araddr: araddr_q, arlen: 8'(isp_pkg::BEATS_PER_PIC - 1), arvalid: arvalid_q};
    assign axi_r_ready = rready_q;
    assign beat = '{valid: bvalid_q, chan: bchan_q, row_pair: brow_q, last: blast_q,
                    data: bdata_q};

endmodule

// File: focus/focus_engine.sv
`timescale 1ns/1ps

module focus_engine (
    input  logic                 clk,
    input  logic                 rst_n,
    input  isp_pkg::pix_beat_t   beat,
    output isp_pkg::focus_res_t  res
);

    localparam int NENT = isp_pkg::CENTER_DIM * isp_pkg::CENTER_DIM;

    logic [9:0]  center_w [NENT];
    logic        first_beat;
    logic        clr_q;

    logic        walk_q;
    logic        vert_q;
    logic [2:0]  wr_q;
    logic [2:0]  wc_q;
    logic [2:0]  col_end;
    logic [2:0]  row_end;
    logic        walk_final;
    logic [2:0]  rb;
    logic [2:0]  cb;
    logic [5:0]  a_idx;
    logic [5:0]  b_idx;
    logic [9:0]  pa;
    logic [9:0]  pb;

    logic        dv_q;
    logic        last1_q;
    logic        last2_q;
    logic        in2_q;
    logic        in4_q;
    logic [9:0]  diff_q;
    logic [11:0] d2_q;
    logic [14:0] d4_q;
    logic [15:0] d6_q;
    logic        res_valid_q;
    logic [9:0]  c2_q;
    logic [9:0]  c4_q;
    logic [9:0]  c6_q;

    // a new picture restarts everything, even a walk still in progress
    assign first_beat = beat.valid && beat.chan == 2'd0 && beat.row_pair == 2'd0;

    // ====================
    // centre buffer, R + 2G + B
    // ====================
    for (genvar e = 0; e < NENT; e++) begin : g_ent
        localparam int PR = e / isp_pkg::CENTER_DIM + 1;
        localparam int PC = e % isp_pkg::CENTER_DIM + 1;
        localparam int BI = (PR % 2) * isp_pkg::IMG_DIM + PC;

        logic [9:0] add_w;
        logic [9:0] ent_q;

        assign add_w = (beat.chan == 2'd1) ? {1'b0, beat.data[BI*8 +: 8], 1'b0}
                                           : {2'b00, beat.data[BI*8 +: 8]};

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                ent_q <= '0;
            end else if (first_beat) begin
                ent_q <= (beat.row_pair == 2'(PR / 2)) ? add_w : '0;
            end else if (beat.valid && beat.row_pair == 2'(PR / 2)) begin
                ent_q <= ent_q + add_w;
            end else if (clr_q) begin
                ent_q <= '0;
            end
        end

        assign center_w[e] = ent_q;
    end

    // ====================
    // pair walk, 30 horizontal then 30 vertical
    // ====================
    assign col_end    = vert_q ? 3'd5 : 3'd4;
    assign row_end    = vert_q ? 3'd4 : 3'd5;
    assign walk_final = vert_q && wr_q == 3'd4 && wc_q == 3'd5;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            walk_q <= 1'b0;
            vert_q <= 1'b0;
            wr_q   <= '0;
            wc_q   <= '0;
        end else if (first_beat) begin
            walk_q <= 1'b0;
            vert_q <= 1'b0;
            wr_q   <= '0;
            wc_q   <= '0;
        end else if (beat.valid && beat.last) begin
            walk_q <= 1'b1;
        end else if (walk_q) begin
            if (wc_q == col_end) begin
                wc_q <= '0;
                if (wr_q == row_end) begin
                    wr_q   <= '0;
                    vert_q <= ~vert_q;
                    if (vert_q) begin
                        walk_q <= 1'b0;
                    end
                end else begin
                    wr_q <= wr_q + 3'd1;
                end
            end else begin
                wc_q <= wc_q + 3'd1;
            end
        end
    end

    // second pixel of the pair
    assign rb    = vert_q ? wr_q + 3'd1 : wr_q;
    assign cb    = vert_q ? wc_q : wc_q + 3'd1;
    assign a_idx = 6'(wr_q) * 6'd6 + 6'(wc_q);
    assign b_idx = vert_q ? a_idx + 6'd6 : a_idx + 6'd1;
    assign pa    = center_w[a_idx];
    assign pb    = center_w[b_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dv_q    <= 1'b0;
            last1_q <= 1'b0;
            last2_q <= 1'b0;
            in2_q   <= 1'b0;
            in4_q   <= 1'b0;
        end else begin
            dv_q    <= walk_q & ~first_beat;
            last1_q <= walk_q & walk_final & ~first_beat;
            last2_q <= last1_q & ~first_beat;
            in4_q   <= wr_q >= 3'd1 && wc_q >= 3'd1 && rb <= 3'd4 && cb <= 3'd4;
            in2_q   <= wr_q >= 3'd2 && wc_q >= 3'd2 && rb <= 3'd3 && cb <= 3'd3;
        end
    end

    always_ff @(posedge clk) begin
        diff_q <= (pa > pb) ? pa - pb : pb - pa;
    end

    // nested window sums
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d2_q <= '0;
            d4_q <= '0;
            d6_q <= '0;
        end else if (first_beat || last2_q) begin
            d2_q <= '0;
            d4_q <= '0;
            d6_q <= '0;
        end else if (dv_q) begin
            d6_q <= d6_q + {6'b0, diff_q};
            if (in4_q) begin
                d4_q <= d4_q + {5'b0, diff_q};
            end
            if (in2_q) begin
                d2_q <= d2_q + {2'b0, diff_q};
            end
        end
    end

    // ====================
    // normalise and report
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid_q <= 1'b0;
            clr_q       <= 1'b0;
        end else begin
            res_valid_q <= last2_q & ~first_beat;
            clr_q       <= last2_q;
        end
    end

    always_ff @(posedge clk) begin
        if (last2_q) begin
            c2_q <= 10'(d2_q >> 4);
            c4_q <= 10'(d4_q >> 6);
            c6_q <= 10'((d6_q >> 2) / 16'd36);
        end
    end

    assign res = '{valid: res_valid_q, c2: c2_q, c4: c4_q, c6: c6_q};

endmodule

// File: exposure/exposure_engine.sv
`timescale 1ns/1ps

module exposure_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  isp_pkg::pix_beat_t  beat,
    input  isp_pkg::isp_cmd_t   cmd,
    output isp_pkg::expo_res_t  res
);

    localparam int NPIX = isp_pkg::PIX_PER_BEAT;

    logic [6:0]  gray_q [NPIX];
    logic [7:0]  s1_q [NPIX/2];
    logic [8:0]  s2_q [NPIX/4];
    logic [9:0]  s3_q [NPIX/8];
    logic [10:0] s4_q;
    logic [4:0]  vld_q;
    logic [4:0]  lst_q;
    logic [13:0] acc_q;
    logic        res_valid_q;

    // double saturates at 255
    function automatic logic [7:0] adjust(input logic [7:0] p, input isp_pkg::ratio_e r);
        case (r)
            isp_pkg::RATIO_QUARTER: return p >> 2;
            isp_pkg::RATIO_HALF:    return p >> 1;
            isp_pkg::RATIO_DOUBLE:  return p[7] ? 8'hff : {p[6:0], 1'b0};
            default:                return p;
        endcase
    endfunction

    // ====================
    // adjust stage and adder tree
    // ====================
    always_ff @(posedge clk) begin
        for (int i = 0; i < NPIX; i++) begin
            gray_q[i] <= (beat.chan == 2'd1) ? 7'(adjust(beat.data[i*8 +: 8], cmd.ratio) >> 1)
                                             : 7'(adjust(beat.data[i*8 +: 8], cmd.ratio) >> 2);
        end
        for (int i = 0; i < NPIX/2; i++) begin
            s1_q[i] <= {1'b0, gray_q[2*i]} + {1'b0, gray_q[2*i+1]};
        end
        for (int i = 0; i < NPIX/4; i++) begin
            s2_q[i] <= {1'b0, s1_q[2*i]} + {1'b0, s1_q[2*i+1]};
        end
        for (int i = 0; i < NPIX/8; i++) begin
            s3_q[i] <= {1'b0, s2_q[2*i]} + {1'b0, s2_q[2*i+1]};
        end
        s4_q <= {1'b0, s3_q[0]} + {1'b0, s3_q[1]};
    end

    // beat valid and last follow the data down the tree
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q       <= '0;
            lst_q       <= '0;
            acc_q       <= '0;
            res_valid_q <= 1'b0;
        end else begin
            vld_q       <= {vld_q[3:0], beat.valid};
            lst_q       <= {lst_q[3:0], beat.valid & beat.last};
            res_valid_q <= lst_q[4];
            if (res_valid_q) begin
                acc_q <= '0;
            end else if (vld_q[4]) begin
                acc_q <= acc_q + {3'b0, s4_q};
            end
        end
    end

    assign res = '{valid: res_valid_q, sum: acc_q};

endmodule

// File: design/isp_result.sv
`timescale 1ns/1ps

module isp_result (
    input  logic                 clk,
    input  logic                 rst_n,
    input  isp_pkg::isp_cmd_t    cmd,
    input  isp_pkg::focus_res_t  focus,
    input  isp_pkg::expo_res_t   expo,
    output logic                 out_valid,
    output logic [7:0]           out_data
);

    logic       sel_valid;
    logic [7:0] sel_data;

    // ties go to the smaller window
    always_comb begin
        if (cmd.mode == isp_pkg::MODE_FOCUS) begin
            sel_valid = focus.valid;
            if (focus.c2 >= focus.c4 && focus.c2 >= focus.c6) begin
                sel_data = 8'd0;
            end else if (focus.c4 >= focus.c6) begin
                sel_data = 8'd1;
            end else begin
                sel_data = 8'd2;
            end
        end else begin
            sel_valid = expo.valid;
            sel_data  = 8'(expo.sum >> 6);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= sel_valid;
            out_data  <= sel_valid ? sel_data : 8'd0;
        end
    end

endmodule

// File: design/isp_top.sv
`timescale 1ns/1ps

module isp_top #(
    parameter logic [isp_pkg::ADDR_W-1:0] PIC_BASE = 32'h10000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  isp_pkg::isp_cmd_t  in_cmd,
    output isp_pkg::axi_ar_t   axi_ar,
    input  logic               axi_ar_ready,
    input  isp_pkg::axi_r_t    axi_r,
    output logic               axi_r_ready,
    output logic               out_valid,
    output logic [7:0]         out_data
);

    isp_pkg::isp_cmd_t           cmd;
    logic                        rd_start;
    logic [isp_pkg::ADDR_W-1:0]  rd_addr;
    isp_pkg::pix_beat_t          beat;
    isp_pkg::focus_res_t         focus_res;
    isp_pkg::expo_res_t          expo_res;

    isp_cmd_decode #(
        .PIC_BASE (PIC_BASE)
    ) isp_cmd_decode_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_cmd    (in_cmd),
        .out_valid (out_valid),
        .cmd       (cmd),
        .rd_start  (rd_start),
        .rd_addr   (rd_addr)
    );

    dram_reader dram_reader_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_start     (rd_start),
        .rd_addr      (rd_addr),
        .axi_ar_ready (axi_ar_ready),
        .axi_r        (axi_r),
        .axi_ar       (axi_ar),
        .axi_r_ready  (axi_r_ready),
        .beat         (beat)
    );

    focus_engine focus_engine_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .beat  (beat),
        .res   (focus_res)
    );

    exposure_engine exposure_engine_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .beat  (beat),
        .cmd   (cmd),
        .res   (expo_res)
    );

    isp_result isp_result_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .focus     (focus_res),
        .expo      (expo_res),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// File: sim/dram_model.sv
`timescale 1ns/1ps

module dram_model #(
    parameter logic [31:0] PIC_BASE = 32'h10000,
    parameter int unsigned SEED     = 32'h297f
) (
    input  logic              clk,
    input  logic              rst_n,
    input  isp_pkg::axi_ar_t  axi_ar,
    output logic              axi_ar_ready,
    output isp_pkg::axi_r_t   axi_r,
    input  logic              axi_r_ready
);

    localparam int MEM_WORDS = 128;

    logic [127:0] pic_mem [MEM_WORDS];

    // AXI read slave, one burst of 12 beats at a time
    initial begin
        logic        ar_hs;
        logic        r_hs;
        logic        rst_seen;
        logic [31:0] addr;
        bit          busy;
        int          base;
        int          cnt;

        busy         = 1'b0;
        base         = 0;
        cnt          = 0;
        axi_ar_ready = 1'b0;
        axi_r        = '0;
        void'($urandom(SEED));
        $readmemh("sim/isp_vectors.txt", pic_mem);
        forever begin
            @(posedge clk);
            ar_hs    = axi_ar.arvalid && axi_ar_ready;
            r_hs     = axi_r.rvalid && axi_r_ready;
            addr     = axi_ar.araddr;
            rst_seen = rst_n;
            #1;
            if (!rst_seen) begin
                busy         = 1'b0;
                cnt          = 0;
                axi_ar_ready = 1'b0;
                axi_r        = '0;
            end else begin
                if (ar_hs) begin
                    busy = 1'b1;
                    cnt  = 0;
                    base = int'((addr - PIC_BASE) / 192) * isp_pkg::BEATS_PER_PIC;
                end
                if (r_hs) begin
                    cnt++;
                    if (cnt == isp_pkg::BEATS_PER_PIC) begin
                        busy = 1'b0;
                    end
                end
                axi_ar_ready = !busy && ($urandom % 4 != 0);
                // a presented beat stays until rready takes it
                if (!axi_r.rvalid || r_hs) begin
                    if (busy && ($urandom % 3 != 0)) begin
                        axi_r = '{rdata: pic_mem[base + cnt],
                                  rlast: (cnt == isp_pkg::BEATS_PER_PIC - 1),
                                  rvalid: 1'b1};
                    end else begin
                        axi_r = '0;
                    end
                end
            end
        end
    end

endmodule

// File: sim/isp_tb.sv
`timescale 1ns/1ps

module isp_tb;

    localparam logic [31:0] PIC_BASE     = 32'h10000;
    localparam int          MEM_WORDS    = 128;
    localparam int          CMD_BASE     = 64;
    localparam int          WAIT_LIMIT   = 2000;
    localparam int          QUIET_CYCLES = 120;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    isp_pkg::isp_cmd_t  in_cmd;
    isp_pkg::axi_ar_t   axi_ar;
    logic               axi_ar_ready;
    isp_pkg::axi_r_t    axi_r;
    logic               axi_r_ready;
    logic               out_valid;
    logic [7:0]         out_data;

    logic [127:0] vec_mem [MEM_WORDS];
    int           errors = 0;
    int           checks = 0;
    int           pulses = 0;
    int           accepted = 0;
    bit           timed_out = 1'b0;
    string        cur_test = "reset";
    logic [3:0]   exp_pic = '0;
    bit           burst_open = 1'b0;
    int           bus_errors = 0;

    isp_top #(
        .PIC_BASE (PIC_BASE)
    ) isp_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_cmd       (in_cmd),
        .axi_ar       (axi_ar),
        .axi_ar_ready (axi_ar_ready),
        .axi_r        (axi_r),
        .axi_r_ready  (axi_r_ready),
        .out_valid    (out_valid),
        .out_data     (out_data)
    );

    dram_model #(
        .PIC_BASE (PIC_BASE),
        .SEED     (32'h297f)
    ) dram_model_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .axi_ar       (axi_ar),
        .axi_ar_ready (axi_ar_ready),
        .axi_r        (axi_r),
        .axi_r_ready  (axi_r_ready)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // every result pulse, wanted or not
    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            pulses <= pulses + 1;
        end
    end

    // read bursts and the idle output
    always @(negedge clk) begin
        logic [31:0] exp_addr;

        exp_addr = PIC_BASE + 32'(exp_pic) * 32'd192;
        if (rst_n) begin
            if (axi_r_ready !== burst_open) begin
                bus_errors++;
                $display("error %s: expected rready %0b, actual %0b", cur_test, burst_open,
                         axi_r_ready);
            end
            if (!out_valid && out_data !== 8'd0) begin
                bus_errors++;
                $display("error %s: expected idle out_data 0, actual %0d", cur_test,
                         out_data);
            end
            if (axi_ar.arvalid && axi_ar_ready) begin
                if (axi_ar.arlen !== 8'd11) begin
                    bus_errors++;
                    $display("error %s: expected arlen 11, actual %0d", cur_test,
                             axi_ar.arlen);
                end
                if (axi_ar.araddr !== exp_addr) begin
                    bus_errors++;
                    $display("error %s: expected araddr %h, actual %h", cur_test, exp_addr,
                             axi_ar.araddr);
                end
                burst_open = 1'b1;
            end
            if (axi_r.rvalid && axi_r_ready && axi_r.rlast) begin
                burst_open = 1'b0;
            end
        end
    end

    // ====================
    // helpers
    // ====================
    task automatic drive_cmd(input isp_pkg::isp_cmd_t c);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_cmd   = c;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_result(output logic [7:0] data, output bit ok);
        ok   = 1'b0;
        data = '0;
        for (int n = 0; n < WAIT_LIMIT && !ok; n++) begin
            @(negedge clk);
            if (out_valid) begin
                ok   = 1'b1;
                data = out_data;
            end
        end
    endtask

    task automatic check_focus(input string name, input logic [1:0] exp_win,
                               input logic [7:0] act);
        checks++;
        if (act !== {6'b0, exp_win}) begin
            errors++;
            $display("error %s: expected window %0d, actual %0d", name, exp_win, act);
        end
    endtask

    task automatic check_expo(input string name, input logic [7:0] exp_avg,
                              input logic [7:0] act);
        checks++;
        if (act !== exp_avg) begin
            errors++;
            $display("error %s: expected average %0d, actual %0d", name, exp_avg, act);
        end
    endtask

    // ====================
    // command sequence
    // ====================
    initial begin
        isp_pkg::isp_cmd_t c;
        isp_pkg::isp_cmd_t busy_cmd;
        logic [127:0]      w;
        logic [7:0]        got;
        bit                ok;
        string             name;
        int                idx;

        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_cmd   = '0;
        $readmemh("sim/isp_vectors.txt", vec_mem);
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        idx = CMD_BASE;
        while (!timed_out && idx < MEM_WORDS && vec_mem[idx][23:20] != 4'd0) begin
            w = vec_mem[idx];
            c = '{pic_no: w[19:16], mode: isp_pkg::isp_mode_e'(w[12]),
                  ratio: isp_pkg::ratio_e'(w[9:8])};
            name = $sformatf("test%0d pic%0d %s ratio%0d", idx - CMD_BASE, c.pic_no,
                             (c.mode == isp_pkg::MODE_FOCUS) ? "focus" : "expo", c.ratio);
            exp_pic  = c.pic_no;
            cur_test = name;
            drive_cmd(c);
            accepted++;
            // second strobe lands while the core is busy and must be dropped
            if (w[23:20] == 4'd2) begin
                busy_cmd = '{pic_no: c.pic_no ^ 4'd1, mode: isp_pkg::isp_mode_e'(~c.mode),
                             ratio: isp_pkg::RATIO_DOUBLE};
                repeat (2) @(posedge clk);
                drive_cmd(busy_cmd);
            end
            wait_result(got, ok);
            if (!ok) begin
                errors++;
                timed_out = 1'b1;
                $display("timeout: no out_valid within %0d cycles in %s", WAIT_LIMIT, name);
            end else if (c.mode == isp_pkg::MODE_FOCUS) begin
                check_focus(name, w[1:0], got);
            end else begin
                check_expo(name, w[7:0], got);
            end
            repeat (QUIET_CYCLES) @(posedge clk);
            if (!timed_out && pulses != accepted) begin
                errors++;
                $display("unexpected out_valid count after %s: %0d pulses for %0d commands",
                         name, pulses, accepted);
                accepted = pulses;
            end
            idx++;
        end

        if (checks == 0) begin
            errors++;
            $display("no test commands were found in the vector file");
        end

        errors = errors + bus_errors;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sim/isp_vectors.txt
// pictures: one 128-bit beat per line, byte 0 is row 2k col 0, beats R 0-3, G 4-7, B 8-11
// commands from @40: flag (1 plain, 2 with busy strobe), pic, mode, ratio, expected byte
// pic0 all 0x80
80808080808080808080808080808080
80808080808080808080808080808080
80808080808080808080808080808080
80808080808080808080808080808080
80808080808080808080808080808080
80808080808080808080808080808080
80808080808080808080808080808080
80808080808080808080808080808080
80808080808080808080808080808080
80808080808080808080808080808080
80808080808080808080808080808080
80808080808080808080808080808080
// pic1 columns alternate 0x00 and 0xff
FF00FF00FF00FF00FF00FF00FF00FF00
FF00FF00FF00FF00FF00FF00FF00FF00
FF00FF00FF00FF00FF00FF00FF00FF00
FF00FF00FF00FF00FF00FF00FF00FF00
FF00FF00FF00FF00FF00FF00FF00FF00
FF00FF00FF00FF00FF00FF00FF00FF00
FF00FF00FF00FF00FF00FF00FF00FF00
FF00FF00FF00FF00FF00FF00FF00FF00
FF00FF00FF00FF00FF00FF00FF00FF00
FF00FF00FF00FF00FF00FF00FF00FF00
FF00FF00FF00FF00FF00FF00FF00FF00
FF00FF00FF00FF00FF00FF00FF00FF00
// pic2 bright pixels at (3,3) and (4,4)
00000000000000000000000000000000
00000000FF0000000000000000000000
0000000000000000000000FF00000000
00000000000000000000000000000000
00000000000000000000000000000000
00000000FF0000000000000000000000
0000000000000000000000FF00000000
00000000000000000000000000000000
00000000000000000000000000000000
00000000FF0000000000000000000000
0000000000000000000000FF00000000
00000000000000000000000000000000
@40
// exposure on pic0 at every ratio, then pic1
101020
101140
101280
1013FD
11127E
// focus on pic0, pic1, pic2
100200
110202
120200
// again with a strobe while busy
210202
21127E
220000
2013FD
000000

// File: filelist.f
common/isp_pkg.sv
design/isp_cmd_decode.sv
design/dram_reader.sv
focus/focus_engine.sv
exposure/exposure_engine.sv
design/isp_result.sv
design/isp_top.sv
sim/dram_model.sv
sim/isp_tb.sv

// File: Makefile
# Verilator build for the ISP core testbench

VERILATOR ?= verilator
TOP       ?= isp_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
